// ==== include/ctrl_defs.svh ====
// widths are fixed by the 32-bit instruction set and are not meant to be changed per build
`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH

////////////////////
// instruction word

// full instruction width
`define INSN_W 32

// major opcode sits in the top bits of the word
`define OPC_W 6

// register file address width
`define REG_AW 5

////////////////////
// branch and link

// branch target is a word address
`define PC_W 30

// jal and jalr always write here
`define LINK_REG 5'd9

////////////////////
// special words

// nop opcode with bit 16 set marks a pipeline bubble
`define NOP_INSN 32'h1401_0000

// xsync sub-codes in bits 25:23
`define XSYNC_SYS 3'b000
`define XSYNC_TRAP 3'b010

`endif

// ==== source/ctrl_pkg.sv ====
// only the kept major opcodes are listed; anything else decodes as illegal in EX
`include "ctrl_defs.svh"

package ctrl_pkg;

	////////////////////
	// major opcodes

	typedef enum logic [`OPC_W-1:0] {
		OPC_J     = 6'h00,
		OPC_JAL   = 6'h01,
		OPC_BNF   = 6'h03,
		OPC_BF    = 6'h04,
		OPC_NOP   = 6'h05,
		OPC_MOVHI = 6'h06,
		OPC_XSYNC = 6'h08,
		OPC_RFE   = 6'h09,
		OPC_JR    = 6'h11,
		OPC_JALR  = 6'h12,
		OPC_LWZ   = 6'h21,
		OPC_LWS   = 6'h22,
		OPC_LBZ   = 6'h23,
		OPC_LBS   = 6'h24,
		OPC_LHZ   = 6'h25,
		OPC_LHS   = 6'h26,
		OPC_ADDI  = 6'h27,
		OPC_ADDIC = 6'h28,
		OPC_ANDI  = 6'h29,
		OPC_ORI   = 6'h2a,
		OPC_XORI  = 6'h2b,
		OPC_SFXXI = 6'h2f,
		OPC_SW    = 6'h35,
		OPC_SB    = 6'h36,
		OPC_SH    = 6'h37,
		OPC_ALU   = 6'h38,
		OPC_SFXX  = 6'h39
	} opcode_e;

	typedef enum logic [2:0] {
		BR_NOP = 3'd0,
		BR_J   = 3'd1,
		BR_JR  = 3'd2,
		BR_BF  = 3'd4,
		BR_BNF = 3'd5,
		BR_RFE = 3'd6
	} branch_op_e;

	////////////////////
	// execute ops

	// low nibble matches the function field of register alu insns
	typedef enum logic [4:0] {
		ALU_ADD = 5'd0, ALU_ADDC = 5'd1, ALU_SUB = 5'd2, ALU_AND = 5'd3,
		ALU_OR = 5'd4, ALU_XOR = 5'd5, ALU_MUL = 5'd6, ALU_RSVD = 5'd7,
		ALU_SHROT = 5'd8, ALU_DIV = 5'd9, ALU_DIVU = 5'd10, ALU_MULU = 5'd11,
		ALU_EXTHB = 5'd12, ALU_EXTW = 5'd13, ALU_CMOV = 5'd14, ALU_FFL1 = 5'd15,
		ALU_MOVHI = 5'd16,
		ALU_COMP  = 5'd17,
		ALU_NOP   = 5'd31
	} alu_op_e;

	// bit 0 is the write enable
	typedef enum logic [2:0] {
		RFWB_NOP = 3'b000,
		RFWB_ALU = 3'b001,
		RFWB_LSU = 3'b011,
		RFWB_SPR = 3'b101,
		RFWB_LR  = 3'b111
	} rfwb_op_e;

	typedef enum logic [3:0] {
		LSU_NOP = 4'b0000,
		LSU_LBZ = 4'b0100,
		LSU_LBS = 4'b0101,
		LSU_LHZ = 4'b0110,
		LSU_LHS = 4'b0111,
		LSU_LWZ = 4'b1000,
		LSU_LWS = 4'b1001,
		LSU_SB  = 4'b1010,
		LSU_SH  = 4'b1100,
		LSU_SW  = 4'b1110
	} lsu_op_e;

	// operand source for the alu inputs
	typedef enum logic [1:0] {
		SEL_RF      = 2'd0,
		SEL_IMM     = 2'd1,
		SEL_EX_FORW = 2'd2,
		SEL_WB_FORW = 2'd3
	} sel_e;

endpackage

// ==== source/id_stage.sv ====
// flushpipe wins over id_freeze; id_simm, id_lsu_op and the branch target are combinational
`timescale 1ns/1ns
`include "ctrl_defs.svh"

module id_stage import ctrl_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [`INSN_W-1:0]    if_insn,
	input  logic [31:0]           id_pc,
	input  logic                  id_freeze,
	input  logic                  flush_req,
	input  logic                  pc_we,
	output logic                  flushpipe,
	output logic [`INSN_W-1:0]    id_insn,
	output branch_op_e            id_branch_op,
	output logic                  sel_imm,
	output logic [31:0]           id_simm,
	output lsu_op_e               id_lsu_op,
	output logic [`PC_W-1:0]      id_branch_target,
	output logic [`REG_AW-1:0]    rf_addra,
	output logic [`REG_AW-1:0]    rf_addrb,
	output logic                  rf_rda,
	output logic                  rf_rdb
);

	logic [`OPC_W-1:0] if_opc;
	logic [`OPC_W-1:0] id_opc;

	assign if_opc = if_insn[`INSN_W-1 -: `OPC_W];
	assign id_opc = id_insn[`INSN_W-1 -: `OPC_W];

	assign flushpipe = flush_req | pc_we;

	// register file read port addresses come straight from fetch
	assign rf_addra = if_insn[20:16];
	assign rf_addrb = if_insn[15:11];
	assign rf_rda = if_insn[31];
	assign rf_rdb = if_insn[30];

	////////////////////
	// id latches

	always_ff @(posedge clk) begin
		if (reset || flushpipe) begin
			id_insn <= `NOP_INSN;
			id_branch_op <= BR_NOP;
		end else if (!id_freeze) begin
			id_insn <= if_insn;
			case (if_opc)
				OPC_J, OPC_JAL:
					id_branch_op <= BR_J;
				OPC_JR, OPC_JALR:
					id_branch_op <= BR_JR;
				OPC_BNF:
					id_branch_op <= BR_BNF;
				OPC_BF:
					id_branch_op <= BR_BF;
				OPC_RFE:
					id_branch_op <= BR_RFE;
				default:
					id_branch_op <= BR_NOP;
			endcase
		end
	end

	// register-form insns take operand b from the register file
	always_ff @(posedge clk) begin
		if (reset) begin
			sel_imm <= 1'b0;
		end else if (!id_freeze) begin
			case (if_opc)
				OPC_JALR, OPC_JR, OPC_RFE, OPC_XSYNC, OPC_SW, OPC_SB, OPC_SH,
				OPC_ALU, OPC_SFXX, OPC_NOP:
					sel_imm <= 1'b0;
				default:
					sel_imm <= 1'b1;
			endcase
		end
	end

	////////////////////
	// immediate and lsu decode

	always_comb begin
		case (id_opc)
			OPC_ADDI, OPC_ADDIC, OPC_XORI, OPC_SFXXI,
			OPC_LWZ, OPC_LWS, OPC_LBZ, OPC_LBS, OPC_LHZ, OPC_LHS:
				id_simm = {{16{id_insn[15]}}, id_insn[15:0]};
			// stores split the offset around the rB field
			OPC_SW, OPC_SB, OPC_SH:
				id_simm = {{16{id_insn[25]}}, id_insn[25:21], id_insn[10:0]};
			default:
				id_simm = {16'h0000, id_insn[15:0]};
		endcase
	end

	always_comb begin
		case (id_opc)
			OPC_LWZ: id_lsu_op = LSU_LWZ;
			OPC_LWS: id_lsu_op = LSU_LWS;
			OPC_LBZ: id_lsu_op = LSU_LBZ;
			OPC_LBS: id_lsu_op = LSU_LBS;
			OPC_LHZ: id_lsu_op = LSU_LHZ;
			OPC_LHS: id_lsu_op = LSU_LHS;
			OPC_SW:  id_lsu_op = LSU_SW;
			OPC_SB:  id_lsu_op = LSU_SB;
			OPC_SH:  id_lsu_op = LSU_SH;
			default: id_lsu_op = LSU_NOP;
		endcase
	end

	// 26-bit word offset relative to the insn's own pc
	assign id_branch_target = {{4{id_insn[25]}}, id_insn[25:0]} + id_pc[31:2];

endmodule

// ==== source/ex_stage.sv ====
// a bubble needs ex_freeze low; with ex_freeze high the stage holds even through a flush
`timescale 1ns/1ns
`include "ctrl_defs.svh"

module ex_stage import ctrl_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [`INSN_W-1:0]    id_insn,
	input  logic [31:0]           id_simm,
	input  branch_op_e            id_branch_op,
	input  logic [`PC_W-1:0]      id_branch_target,
	input  logic                  ex_freeze,
	input  logic                  id_freeze,
	input  logic                  flushpipe,
	input  logic                  du_hwbkpt,
	output logic [`INSN_W-1:0]    ex_insn,
	output branch_op_e            ex_branch_op,
	output logic [`PC_W-1:0]      ex_branch_target,
	output logic [31:0]           ex_simm,
	output alu_op_e               alu_op,
	output logic [3:0]            alu_op2,
	output logic [3:0]            comp_op,
	output rfwb_op_e              rfwb_op,
	output logic [`REG_AW-1:0]    rf_addrw,
	output logic                  except_illegal,
	output logic                  sig_syscall,
	output logic                  sig_trap,
	output logic                  rfe
);

	logic [`OPC_W-1:0] id_opc;
	logic bubble;
	alu_op_e dec_alu_op;
	rfwb_op_e dec_rfwb_op;
	logic [`REG_AW-1:0] dec_addrw;
	logic dec_illegal;
	logic dec_syscall;
	logic dec_trap;

	assign id_opc = id_insn[`INSN_W-1 -: `OPC_W];

	// ID stalled while EX moves on
	assign bubble = !ex_freeze && (id_freeze || flushpipe);

	////////////////////
	// decode of id_insn

	always_comb begin
		case (id_opc)
			OPC_MOVHI: dec_alu_op = ALU_MOVHI;
			OPC_ADDI:  dec_alu_op = ALU_ADD;
			OPC_ADDIC: dec_alu_op = ALU_ADDC;
			OPC_ANDI:  dec_alu_op = ALU_AND;
			OPC_ORI:   dec_alu_op = ALU_OR;
			OPC_XORI:  dec_alu_op = ALU_XOR;
			OPC_SFXXI, OPC_SFXX:
				dec_alu_op = ALU_COMP;
			OPC_ALU:
				dec_alu_op = alu_op_e'({1'b0, id_insn[3:0]});
			default:
				dec_alu_op = ALU_NOP;
		endcase
	end

	always_comb begin
		case (id_opc)
			OPC_JAL, OPC_JALR:
				dec_rfwb_op = RFWB_LR;
			OPC_LWZ, OPC_LWS, OPC_LBZ, OPC_LBS, OPC_LHZ, OPC_LHS:
				dec_rfwb_op = RFWB_LSU;
			OPC_MOVHI, OPC_ADDI, OPC_ADDIC, OPC_ANDI, OPC_ORI, OPC_XORI, OPC_ALU:
				dec_rfwb_op = RFWB_ALU;
			default:
				dec_rfwb_op = RFWB_NOP;
		endcase
	end

	always_comb begin
		case (id_opc)
			// div, mul, ff1 and ext are not built
			OPC_ALU:
				case (id_insn[4:0])
					ALU_DIV, ALU_DIVU, ALU_MUL, ALU_FFL1, ALU_EXTHB, ALU_EXTW:
						dec_illegal = 1'b1;
					default:
						dec_illegal = 1'b0;
				endcase
			OPC_J, OPC_JAL, OPC_JALR, OPC_JR, OPC_BNF, OPC_BF, OPC_RFE, OPC_MOVHI,
			OPC_XSYNC, OPC_LWZ, OPC_LWS, OPC_LBZ, OPC_LBS, OPC_LHZ, OPC_LHS,
			OPC_ADDI, OPC_ADDIC, OPC_ANDI, OPC_ORI, OPC_XORI, OPC_SFXXI,
			OPC_SW, OPC_SB, OPC_SH, OPC_SFXX, OPC_NOP:
				dec_illegal = 1'b0;
			default:
				dec_illegal = 1'b1;
		endcase
	end

	// link register for jal and jalr
	assign dec_addrw = (id_opc == OPC_JAL || id_opc == OPC_JALR) ? `LINK_REG : id_insn[25:21];

	assign dec_syscall = (id_opc == OPC_XSYNC) && (id_insn[25:23] == `XSYNC_SYS);
	assign dec_trap = ((id_opc == OPC_XSYNC) && (id_insn[25:23] == `XSYNC_TRAP)) || du_hwbkpt;

	////////////////////
	// ex registers

	always_ff @(posedge clk) begin
		if (reset || bubble) begin
			ex_insn <= `NOP_INSN;
			ex_branch_op <= BR_NOP;
			alu_op <= ALU_NOP;
			alu_op2 <= 4'd0;
			comp_op <= 4'd0;
			rfwb_op <= RFWB_NOP;
			rf_addrw <= '0;
			except_illegal <= 1'b0;
			sig_syscall <= 1'b0;
			sig_trap <= 1'b0;
		end else if (!ex_freeze) begin
			ex_insn <= id_insn;
			ex_branch_op <= id_branch_op;
			alu_op <= dec_alu_op;
			alu_op2 <= id_insn[9:6];
			comp_op <= id_insn[24:21];
			rfwb_op <= dec_rfwb_op;
			rf_addrw <= dec_addrw;
			except_illegal <= dec_illegal;
			sig_syscall <= dec_syscall;
			sig_trap <= dec_trap;
		end
	end

	// payload follows ID whenever EX advances
	always_ff @(posedge clk) begin
		if (!ex_freeze) begin
			ex_simm <= id_simm;
			ex_branch_target <= id_branch_target;
		end
	end

	assign rfe = (id_branch_op == BR_RFE) || (ex_branch_op == BR_RFE);

endmodule

// ==== source/wb_stage.sv ====
// forwarding compares the ID operand fields against EX and WB write addresses; no bubble in WB
`timescale 1ns/1ns
`include "ctrl_defs.svh"

module wb_stage import ctrl_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  wb_freeze,
	input  logic [`INSN_W-1:0]    ex_insn,
	input  logic [`INSN_W-1:0]    id_insn,
	input  logic                  sel_imm,
	input  logic [`REG_AW-1:0]    rf_addrw,
	input  rfwb_op_e              rfwb_op,
	input  logic                  wbforw_valid,
	output logic [`INSN_W-1:0]    wb_insn,
	output sel_e                  sel_a,
	output sel_e                  sel_b
);

	logic [`REG_AW-1:0] wb_rfaddrw;

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_insn <= `NOP_INSN;
			wb_rfaddrw <= '0;
		end else if (!wb_freeze) begin
			wb_insn <= ex_insn;
			wb_rfaddrw <= rf_addrw;
		end
	end

	////////////////////
	// operand select

	// EX result is newer than WB so it wins
	function automatic sel_e pick_src(
		input logic [`REG_AW-1:0] addr,
		input logic [`REG_AW-1:0] ex_addr,
		input logic               ex_we,
		input logic [`REG_AW-1:0] wb_addr,
		input logic               wb_valid
	);
		if (addr == ex_addr && ex_we)
			return SEL_EX_FORW;
		else if (addr == wb_addr && wb_valid)
			return SEL_WB_FORW;
		else
			return SEL_RF;
	endfunction

	always_comb begin
		sel_a = pick_src(id_insn[20:16], rf_addrw, rfwb_op[0], wb_rfaddrw, wbforw_valid);
		// immediate overrides any forwarding on operand b
		if (sel_imm)
			sel_b = SEL_IMM;
		else
			sel_b = pick_src(id_insn[15:11], rf_addrw, rfwb_op[0], wb_rfaddrw, wbforw_valid);
	end

endmodule

// ==== source/pipe_ctrl.sv ====
// freezes are levels from the core; flush_req and pc_we are one-cycle strobes
`timescale 1ns/1ns
`include "ctrl_defs.svh"

module pipe_ctrl import ctrl_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [`INSN_W-1:0]    if_insn,
	input  logic [31:0]           id_pc,
	input  logic                  id_freeze,
	input  logic                  ex_freeze,
	input  logic                  wb_freeze,
	input  logic                  flush_req,
	input  logic                  pc_we,
	input  logic                  wbforw_valid,
	input  logic                  du_hwbkpt,
	// decode stage
	output logic                  flushpipe,
	output logic [`INSN_W-1:0]    id_insn,
	output branch_op_e            id_branch_op,
	output logic                  sel_imm,
	output logic [31:0]           id_simm,
	output lsu_op_e               id_lsu_op,
	output logic [`PC_W-1:0]      id_branch_target,
	output logic [`REG_AW-1:0]    rf_addra,
	output logic [`REG_AW-1:0]    rf_addrb,
	output logic                  rf_rda,
	output logic                  rf_rdb,
	// execute stage
	output logic [`INSN_W-1:0]    ex_insn,
	output branch_op_e            ex_branch_op,
	output logic [`PC_W-1:0]      ex_branch_target,
	output logic [31:0]           ex_simm,
	output alu_op_e               alu_op,
	output logic [3:0]            alu_op2,
	output logic [3:0]            comp_op,
	output rfwb_op_e              rfwb_op,
	output logic [`REG_AW-1:0]    rf_addrw,
	output logic                  except_illegal,
	output logic                  sig_syscall,
	output logic                  sig_trap,
	output logic                  rfe,
	// result stage
	output logic [`INSN_W-1:0]    wb_insn,
	output sel_e                  sel_a,
	output sel_e                  sel_b
);

	id_stage i_id_stage (
		.clk, .reset, .if_insn, .id_pc, .id_freeze, .flush_req, .pc_we,
		.flushpipe, .id_insn, .id_branch_op, .sel_imm, .id_simm, .id_lsu_op,
		.id_branch_target, .rf_addra, .rf_addrb, .rf_rda, .rf_rdb
	);

	ex_stage i_ex_stage (
		.clk, .reset, .id_insn, .id_simm, .id_branch_op, .id_branch_target,
		.ex_freeze, .id_freeze, .flushpipe, .du_hwbkpt,
		.ex_insn, .ex_branch_op, .ex_branch_target, .ex_simm, .alu_op, .alu_op2,
		.comp_op, .rfwb_op, .rf_addrw, .except_illegal, .sig_syscall, .sig_trap, .rfe
	);

	// forwarding looks at the EX write port and the WB copy of it
	wb_stage i_wb_stage (
		.clk, .reset, .wb_freeze, .ex_insn, .id_insn, .sel_imm, .rf_addrw,
		.rfwb_op, .wbforw_valid, .wb_insn, .sel_a, .sel_b
	);

endmodule

// ==== verification/pipe_ctrl_checker.sv ====
// model steps on the rising edge and compares at the falling edge, only while reset is low
`timescale 1ns/1ns
`include "ctrl_defs.svh"

module pipe_ctrl_checker import ctrl_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  test_end,
	input  logic [`INSN_W-1:0]    if_insn,
	input  logic [31:0]           id_pc,
	input  logic                  id_freeze,
	input  logic                  ex_freeze,
	input  logic                  wb_freeze,
	input  logic                  flush_req,
	input  logic                  pc_we,
	input  logic                  wbforw_valid,
	input  logic                  du_hwbkpt,
	input  logic                  flushpipe,
	input  logic [`INSN_W-1:0]    id_insn,
	input  branch_op_e            id_branch_op,
	input  logic                  sel_imm,
	input  logic [31:0]           id_simm,
	input  lsu_op_e               id_lsu_op,
	input  logic [`PC_W-1:0]      id_branch_target,
	input  logic [`REG_AW-1:0]    rf_addra,
	input  logic [`REG_AW-1:0]    rf_addrb,
	input  logic                  rf_rda,
	input  logic                  rf_rdb,
	input  logic [`INSN_W-1:0]    ex_insn,
	input  branch_op_e            ex_branch_op,
	input  logic [`PC_W-1:0]      ex_branch_target,
	input  logic [31:0]           ex_simm,
	input  alu_op_e               alu_op,
	input  logic [3:0]            alu_op2,
	input  logic [3:0]            comp_op,
	input  rfwb_op_e              rfwb_op,
	input  logic [`REG_AW-1:0]    rf_addrw,
	input  logic                  except_illegal,
	input  logic                  sig_syscall,
	input  logic                  sig_trap,
	input  logic                  rfe,
	input  logic [`INSN_W-1:0]    wb_insn,
	input  sel_e                  sel_a,
	input  sel_e                  sel_b,
	output int                    err_count,
	output int                    check_count
);

	logic flush_now;
	logic bubble_now;
	logic [`INSN_W-1:0] m_id_insn;
	branch_op_e m_id_br;
	logic m_sel_imm;
	logic [`INSN_W-1:0] m_ex_insn;
	branch_op_e m_ex_br;
	logic [31:0] m_ex_simm;
	logic [`PC_W-1:0] m_ex_target;
	alu_op_e m_alu_op;
	logic [3:0] m_alu_op2;
	logic [3:0] m_comp_op;
	rfwb_op_e m_rfwb;
	logic [`REG_AW-1:0] m_addrw;
	logic m_illegal;
	logic m_syscall;
	logic m_trap;
	logic [`INSN_W-1:0] m_wb_insn;
	logic [`REG_AW-1:0] m_wb_addrw;
	int test_idx = 0;
	int test_checks = 0;
	int test_errs = 0;

	assign flush_now = flush_req | pc_we;
	assign bubble_now = !ex_freeze && (id_freeze || flush_now);

	////////////////////
	// decode rules

	function automatic branch_op_e branch_of(input logic [`OPC_W-1:0] opc);
		case (opc)
			OPC_J, OPC_JAL: return BR_J;
			OPC_JR, OPC_JALR: return BR_JR;
			OPC_BNF: return BR_BNF;
			OPC_BF: return BR_BF;
			OPC_RFE: return BR_RFE;
			default: return BR_NOP;
		endcase
	endfunction

	// register forms read rB instead of an immediate
	function automatic logic takes_imm(input logic [`OPC_W-1:0] opc);
		case (opc)
			OPC_JALR, OPC_JR, OPC_RFE, OPC_XSYNC, OPC_SW, OPC_SB, OPC_SH,
			OPC_ALU, OPC_SFXX, OPC_NOP: return 1'b0;
			default: return 1'b1;
		endcase
	endfunction

	function automatic logic [31:0] extend_imm(input logic [`INSN_W-1:0] insn);
		case (insn[31:26])
			OPC_ADDI, OPC_ADDIC, OPC_XORI, OPC_SFXXI, OPC_LWZ, OPC_LWS,
			OPC_LBZ, OPC_LBS, OPC_LHZ, OPC_LHS:
				return {{16{insn[15]}}, insn[15:0]};
			OPC_SW, OPC_SB, OPC_SH:
				return {{16{insn[25]}}, insn[25:21], insn[10:0]};
			default:
				return {16'h0000, insn[15:0]};
		endcase
	endfunction

	function automatic lsu_op_e lsu_of(input logic [`INSN_W-1:0] insn);
		case (insn[31:26])
			OPC_LWZ: return LSU_LWZ;
			OPC_LWS: return LSU_LWS;
			OPC_LBZ: return LSU_LBZ;
			OPC_LBS: return LSU_LBS;
			OPC_LHZ: return LSU_LHZ;
			OPC_LHS: return LSU_LHS;
			OPC_SW: return LSU_SW;
			OPC_SB: return LSU_SB;
			OPC_SH: return LSU_SH;
			default: return LSU_NOP;
		endcase
	endfunction

	function automatic logic [`PC_W-1:0] branch_addr(input logic [`INSN_W-1:0] insn,
			input logic [31:0] pc);
		return {{4{insn[25]}}, insn[25:0]} + pc[31:2];
	endfunction

	function automatic alu_op_e alu_of(input logic [`INSN_W-1:0] insn);
		case (insn[31:26])
			OPC_MOVHI: return ALU_MOVHI;
			OPC_ADDI: return ALU_ADD;
			OPC_ADDIC: return ALU_ADDC;
			OPC_ANDI: return ALU_AND;
			OPC_ORI: return ALU_OR;
			OPC_XORI: return ALU_XOR;
			OPC_SFXXI, OPC_SFXX: return ALU_COMP;
			OPC_ALU: return alu_op_e'({1'b0, insn[3:0]});
			default: return ALU_NOP;
		endcase
	endfunction

	function automatic rfwb_op_e wb_src_of(input logic [`OPC_W-1:0] opc);
		case (opc)
			OPC_JAL, OPC_JALR: return RFWB_LR;
			OPC_LWZ, OPC_LWS, OPC_LBZ, OPC_LBS, OPC_LHZ, OPC_LHS: return RFWB_LSU;
			OPC_MOVHI, OPC_ADDI, OPC_ADDIC, OPC_ANDI, OPC_ORI, OPC_XORI, OPC_ALU:
				return RFWB_ALU;
			default: return RFWB_NOP;
		endcase
	endfunction

	function automatic logic is_illegal(input logic [`INSN_W-1:0] insn);
		case (insn[31:26])
			// div, divu, mul, ff1 and both ext forms
			OPC_ALU: return insn[4:0] == 5'd6 || insn[4:0] == 5'd9 || insn[4:0] == 5'd10 ||
				insn[4:0] == 5'd12 || insn[4:0] == 5'd13 || insn[4:0] == 5'd15;
			OPC_J, OPC_JAL, OPC_JALR, OPC_JR, OPC_BNF, OPC_BF, OPC_RFE, OPC_MOVHI,
			OPC_XSYNC, OPC_LWZ, OPC_LWS, OPC_LBZ, OPC_LBS, OPC_LHZ, OPC_LHS,
			OPC_ADDI, OPC_ADDIC, OPC_ANDI, OPC_ORI, OPC_XORI, OPC_SFXXI,
			OPC_SW, OPC_SB, OPC_SH, OPC_SFXX, OPC_NOP: return 1'b0;
			default: return 1'b1;
		endcase
	endfunction

	// newest writer first
	function automatic sel_e operand_src(input logic [`REG_AW-1:0] addr);
		if (addr == m_addrw && m_rfwb[0])
			return SEL_EX_FORW;
		if (addr == m_wb_addrw && wbforw_valid)
			return SEL_WB_FORW;
		return SEL_RF;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		test_checks++;
		if (expected !== actual) begin
			err_count++;
			test_errs++;
			$display("[FAIL] %s expected %h got %h at %0t", name, expected, actual, $time);
		end
	endtask

	////////////////////
	// pipeline model

	always @(posedge clk) begin
		if (reset || flush_now) begin
			m_id_insn <= `NOP_INSN;
			m_id_br <= BR_NOP;
		end else if (!id_freeze) begin
			m_id_insn <= if_insn;
			m_id_br <= branch_of(if_insn[31:26]);
		end
		if (reset)
			m_sel_imm <= 1'b0;
		else if (!id_freeze)
			m_sel_imm <= takes_imm(if_insn[31:26]);
		if (!ex_freeze) begin
			m_ex_simm <= extend_imm(m_id_insn);
			m_ex_target <= branch_addr(m_id_insn, id_pc);
		end
		if (reset || bubble_now) begin
			m_ex_insn <= `NOP_INSN;
			m_ex_br <= BR_NOP;
			m_alu_op <= ALU_NOP;
			m_alu_op2 <= 4'd0;
			m_comp_op <= 4'd0;
			m_rfwb <= RFWB_NOP;
			m_addrw <= '0;
			m_illegal <= 1'b0;
			m_syscall <= 1'b0;
			m_trap <= 1'b0;
		end else if (!ex_freeze) begin
			m_ex_insn <= m_id_insn;
			m_ex_br <= m_id_br;
			m_alu_op <= alu_of(m_id_insn);
			m_alu_op2 <= m_id_insn[9:6];
			m_comp_op <= m_id_insn[24:21];
			m_rfwb <= wb_src_of(m_id_insn[31:26]);
			m_addrw <= (m_id_insn[31:26] == OPC_JAL || m_id_insn[31:26] == OPC_JALR) ?
				`LINK_REG : m_id_insn[25:21];
			m_illegal <= is_illegal(m_id_insn);
			m_syscall <= m_id_insn[31:26] == OPC_XSYNC && m_id_insn[25:23] == 3'b000;
			m_trap <= (m_id_insn[31:26] == OPC_XSYNC && m_id_insn[25:23] == 3'b010) ||
				du_hwbkpt;
		end
		if (reset) begin
			m_wb_insn <= `NOP_INSN;
			m_wb_addrw <= '0;
		end else if (!wb_freeze) begin
			m_wb_insn <= m_ex_insn;
			m_wb_addrw <= m_addrw;
		end
	end

	////////////////////
	// comparisons

	initial begin
		err_count = 0;
		check_count = 0;
	end

	always @(negedge clk) begin
		if (!reset) begin
			compare_value("flushpipe", flush_now, flushpipe);
			compare_value("id_insn", m_id_insn, id_insn);
			compare_value("id_branch_op", m_id_br, id_branch_op);
			compare_value("sel_imm", m_sel_imm, sel_imm);
			compare_value("id_simm", extend_imm(m_id_insn), id_simm);
			compare_value("id_lsu_op", lsu_of(m_id_insn), id_lsu_op);
			compare_value("id_branch_target", branch_addr(m_id_insn, id_pc), id_branch_target);
			// read ports address rA and rB of the fetched word
			compare_value("rf_addra", if_insn[20:16], rf_addra);
			compare_value("rf_addrb", if_insn[15:11], rf_addrb);
			compare_value("rf_rda", if_insn[31], rf_rda);
			compare_value("rf_rdb", if_insn[30], rf_rdb);
			compare_value("ex_insn", m_ex_insn, ex_insn);
			compare_value("ex_branch_op", m_ex_br, ex_branch_op);
			compare_value("ex_branch_target", m_ex_target, ex_branch_target);
			compare_value("ex_simm", m_ex_simm, ex_simm);
			compare_value("alu_op", m_alu_op, alu_op);
			compare_value("alu_op2", m_alu_op2, alu_op2);
			compare_value("comp_op", m_comp_op, comp_op);
			compare_value("rfwb_op", m_rfwb, rfwb_op);
			compare_value("rf_addrw", m_addrw, rf_addrw);
			compare_value("except_illegal", m_illegal, except_illegal);
			compare_value("sig_syscall", m_syscall, sig_syscall);
			compare_value("sig_trap", m_trap, sig_trap);
			compare_value("rfe", m_id_br == BR_RFE || m_ex_br == BR_RFE, rfe);
			compare_value("wb_insn", m_wb_insn, wb_insn);
			compare_value("sel_a", operand_src(m_id_insn[20:16]), sel_a);
			compare_value("sel_b", m_sel_imm ? SEL_IMM : operand_src(m_id_insn[15:11]), sel_b);
		end
		if (test_end) begin
			$display("test %0d finished: %0d checks, %0d errors", test_idx, test_checks,
				test_errs);
			test_idx++;
			test_checks = 0;
			test_errs = 0;
		end
	end

endmodule

// ==== verification/pipe_ctrl_assert.sv ====
// bound into pipe_ctrl; covers only the flush and bubble paths, not the decode tables
`timescale 1ns/1ns
`include "ctrl_defs.svh"

module pipe_ctrl_assert (
	input logic                 clk,
	input logic                 reset,
	input logic                 flushpipe,
	input logic                 id_freeze,
	input logic                 ex_freeze,
	input logic [`INSN_W-1:0]   id_insn,
	input logic [`INSN_W-1:0]   ex_insn,
	input logic                 except_illegal,
	input logic [`REG_AW-1:0]   rf_addrw
);

	logic bubble;
	// failures seen so far
	int fail_count = 0;

	// EX moves on while ID is stalled or flushed
	assign bubble = !ex_freeze && (id_freeze || flushpipe);

	flush_gives_nop: assert property (@(posedge clk) disable iff (reset)
		flushpipe |=> id_insn == `NOP_INSN)
		else begin
			fail_count++;
			$error("flush did not leave a nop in id_insn");
		end

	bubble_gives_nop: assert property (@(posedge clk) disable iff (reset)
		bubble |=> (ex_insn == `NOP_INSN && !except_illegal))
		else begin
			fail_count++;
			$error("bubble did not leave a clean nop in ex_insn");
		end

	bubble_clears_addrw: assert property (@(posedge clk) disable iff (reset)
		bubble |=> rf_addrw == '0)
		else begin
			fail_count++;
			$error("bubble left a nonzero write address");
		end

endmodule

bind pipe_ctrl pipe_ctrl_assert i_pipe_ctrl_assert (.*);

// ==== verification/pipe_ctrl_tb.sv ====
// six random tests of 400 cycles from seed 44; odd tests narrow the register fields
`timescale 1ns/1ns
`include "ctrl_defs.svh"

module pipe_ctrl_tb import ctrl_pkg::*; ();

	localparam int NUM_TESTS = 6;
	localparam int TEST_CYCLES = 400;
	localparam int CLK_PERIOD = 8;
	// reset plus test cycles with some slack
	localparam int TIMEOUT_CYC = NUM_TESTS * TEST_CYCLES + 600;

	// kept opcodes followed by three undefined ones
	localparam logic [29:0][`OPC_W-1:0] OPC_POOL = {
		OPC_J, OPC_JAL, OPC_BNF, OPC_BF, OPC_NOP, OPC_MOVHI, OPC_XSYNC, OPC_RFE,
		OPC_JR, OPC_JALR, OPC_LWZ, OPC_LWS, OPC_LBZ, OPC_LBS, OPC_LHZ, OPC_LHS,
		OPC_ADDI, OPC_ADDIC, OPC_ANDI, OPC_ORI, OPC_XORI, OPC_SFXXI,
		OPC_SW, OPC_SB, OPC_SH, OPC_ALU, OPC_SFXX, 6'h0a, 6'h1c, 6'h3e
	};

	logic clk;
	logic reset;
	logic [`INSN_W-1:0] if_insn;
	logic [31:0] id_pc;
	logic id_freeze;
	logic ex_freeze;
	logic wb_freeze;
	logic flush_req;
	logic pc_we;
	logic wbforw_valid;
	logic du_hwbkpt;
	logic flushpipe;
	logic [`INSN_W-1:0] id_insn;
	branch_op_e id_branch_op;
	logic sel_imm;
	logic [31:0] id_simm;
	lsu_op_e id_lsu_op;
	logic [`PC_W-1:0] id_branch_target;
	logic [`REG_AW-1:0] rf_addra;
	logic [`REG_AW-1:0] rf_addrb;
	logic rf_rda;
	logic rf_rdb;
	logic [`INSN_W-1:0] ex_insn;
	branch_op_e ex_branch_op;
	logic [`PC_W-1:0] ex_branch_target;
	logic [31:0] ex_simm;
	alu_op_e alu_op;
	logic [3:0] alu_op2;
	logic [3:0] comp_op;
	rfwb_op_e rfwb_op;
	logic [`REG_AW-1:0] rf_addrw;
	logic except_illegal;
	logic sig_syscall;
	logic sig_trap;
	logic rfe;
	logic [`INSN_W-1:0] wb_insn;
	sel_e sel_a;
	sel_e sel_b;
	logic test_end;
	logic narrow_regs;
	int err_count;
	int check_count;
	int cycle_cnt = 0;

	pipe_ctrl i_pipe_ctrl (.*);

	pipe_ctrl_checker i_checker (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////
	// stimulus

	// a frozen stage also freezes every earlier stage
	task automatic drive_random();
		logic [31:0] r;
		r = $urandom;
		if (narrow_regs) begin
			r[25:23] = 3'd0;
			r[20:18] = 3'd0;
			r[15:13] = 3'd0;
		end
		if_insn = {OPC_POOL[$urandom % 30], r[25:0]};
		id_pc = $urandom;
		wb_freeze = ($urandom % 100) < 15;
		ex_freeze = wb_freeze || (($urandom % 100) < 15);
		id_freeze = ex_freeze || (($urandom % 100) < 15);
		flush_req = ($urandom % 100) < 5;
		pc_we = ($urandom % 100) < 5;
		wbforw_valid = $urandom % 2;
		du_hwbkpt = ($urandom % 8) == 0;
	endtask

	initial begin
		void'($urandom(44));
		reset = 1'b1;
		if_insn = `NOP_INSN;
		id_pc = '0;
		id_freeze = 1'b0;
		ex_freeze = 1'b0;
		wb_freeze = 1'b0;
		flush_req = 1'b0;
		pc_we = 1'b0;
		wbforw_valid = 1'b0;
		du_hwbkpt = 1'b0;
		test_end = 1'b0;
		narrow_regs = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			narrow_regs = t[0];
			repeat (TEST_CYCLES) begin
				@(posedge clk);
				#1;
				test_end = 1'b0;
				drive_random();
			end
			@(posedge clk);
			#1;
			test_end = 1'b1;
		end
		@(posedge clk);
		#1;
		test_end = 1'b0;
		@(negedge clk);
		$display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
			NUM_TESTS, check_count, err_count, i_pipe_ctrl.i_pipe_ctrl_assert.fail_count);
		if (err_count == 0 && check_count > 0 &&
				i_pipe_ctrl.i_pipe_ctrl_assert.fail_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	////////////////////
	// watchdog

	always @(posedge clk)
		cycle_cnt <= cycle_cnt + 1;

	initial begin
		while (cycle_cnt < TIMEOUT_CYC)
			@(posedge clk);
		$display("timeout: tests did not finish");
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+include
source/ctrl_pkg.sv
source/id_stage.sv
source/ex_stage.sv
source/wb_stage.sv
source/pipe_ctrl.sv
verification/pipe_ctrl_checker.sv
verification/pipe_ctrl_assert.sv
verification/pipe_ctrl_tb.sv
